// File: common/div_defines.svh
/* Division cluster configuration
   Lane count and request tag width shared by the package and the cluster RTL */

`ifndef DIV_DEFINES_SVH
`define DIV_DEFINES_SVH

////////////////////////////////////////////////////////////////////////////
// Cluster sizing
////////////////////////////////////////////////////////////////////////////

// Number of serial divider lanes, any value from 1 to 8
`define DIV_N_LANES 4

// Width of the tag that travels with each request
`define DIV_TAG_W 4

`endif

// File: common/div_pkg.sv
/* Division cluster package
   Opcode and lane state encodings, request and response records */

`default_nettype none

`include "div_defines.svh"

package div_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////////////////////

  // RISC-V M extension division opcodes
  // Bit 0 selects unsigned, bit 1 selects remainder
  typedef enum logic [1:0] {
    DIV_DIV  = 2'b00,
    DIV_DIVU = 2'b01,
    DIV_REM  = 2'b10,
    DIV_REMU = 2'b11
  } div_op_e;

  // Serial lane FSM states
  typedef enum logic [1:0] {
    DIV_IDLE   = 2'b00,
    DIV_DIVIDE = 2'b01,
    DIV_DUMMY  = 2'b10,
    DIV_FINISH = 2'b11
  } div_state_e;

  ////////////////////////////////////////////////////////////////////////////
  // Records
  ////////////////////////////////////////////////////////////////////////////

  // Request toward a lane, operands in RISC-V order (op_a / op_b)
  typedef struct packed {
    div_op_e                op;
    logic [31:0]            op_a;
    logic [31:0]            op_b;
    logic [`DIV_TAG_W-1:0]  tag;
  } div_req_t;

  // Result with the tag of its request
  typedef struct packed {
    logic [31:0]            result;
    logic [`DIV_TAG_W-1:0]  tag;
  } div_rsp_t;

endpackage

`default_nettype wire

// File: div_lane/div_norm.sv
/* Divisor normalizer
   Leading-zero count of the selected word and left shift of the divisor by it */

`default_nettype none

module div_norm (
  input  logic [31:0] data_i,
  input  logic [31:0] op_b_i,
  output logic [5:0]  clz_o,
  output logic [31:0] shifted_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Leading-zero count
  ////////////////////////////////////////////////////////////////////////////

  // Binary search, each stage decides one bit of the count
  logic [4:0]  cnt;
  logic [31:0] stg16;
  logic [31:0] stg8;
  logic [31:0] stg4;
  logic [31:0] stg2;
  logic        all_zero;

  // Upper half empty
  assign cnt[4] = ~|data_i[31:16];
  assign stg16  = cnt[4] ? {data_i[15:0], 16'h0000} : data_i;

  // Upper byte empty
  assign cnt[3] = ~|stg16[31:24];
  assign stg8   = cnt[3] ? {stg16[23:0], 8'h00} : stg16;

  // Upper nibble empty
  assign cnt[2] = ~|stg8[31:28];
  assign stg4   = cnt[2] ? {stg8[27:0], 4'h0} : stg8;

  // Upper pair empty
  assign cnt[1] = ~|stg4[31:30];
  assign stg2   = cnt[1] ? {stg4[29:0], 2'b00} : stg4;

  // Last stage only looks at the MSB
  assign cnt[0] = ~stg2[31];

  // Search alone gives 31 for a zero word
  assign all_zero = ~|data_i;
  assign clz_o    = all_zero ? 6'd32 : {1'b0, cnt};

  ////////////////////////////////////////////////////////////////////////////
  // Alignment shift
  ////////////////////////////////////////////////////////////////////////////

  // A count of 32 shifts everything out, only seen for a zero divisor
  assign shifted_o = op_b_i << clz_o;

endmodule

`default_nettype wire

// File: div_lane/div_serial.sv
/* Serial restoring divider lane
   One quotient bit per cycle, RISC-V signed and unsigned DIV / REM semantics */

`default_nettype none

`include "div_defines.svh"

module div_serial (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              data_ind_timing_i,
  input  logic              valid_i,
  input  div_pkg::div_req_t req_i,
  output logic              valid_o,
  input  logic              ready_i,
  output div_pkg::div_rsp_t rsp_o
);

  import div_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Declarations
  ////////////////////////////////////////////////////////////////////////////

  div_state_e state_q;
  div_state_e state_d;

  // Opcode decode
  logic        div_signed;
  logic        div_rem;
  logic        op_a_neg;
  logic        op_b_neg;
  logic        op_b_zero;
  logic        signs_differ;

  // Normalizer interface
  logic [31:0] norm_data;
  logic [5:0]  norm_clz;
  logic [31:0] norm_shifted;

  // Datapath registers
  logic [31:0] rem_q;
  logic [31:0] divisor_q;
  logic [31:0] quo_q;
  logic [`DIV_TAG_W-1:0] tag_q;
  logic        rem_sel_q;
  logic        comp_inv_q;
  logic        res_inv_q;

  // Datapath nets
  logic [31:0] add_a;
  logic [31:0] add_b;
  logic [31:0] add_out;
  logic [31:0] res_mux;
  logic [31:0] res_out;
  logic        comp_out;
  logic        init_pos;

  // Counter
  logic [5:0]  cnt_q;
  logic [5:0]  cnt_d;
  logic [5:0]  cnt_pad;
  logic        cnt_zero;

  // FSM enables
  logic        init_en;
  logic        pad_load;
  logic        rem_en;
  logic        divisor_en;
  logic        quo_en;

  ////////////////////////////////////////////////////////////////////////////
  // Operand decode and normalization
  ////////////////////////////////////////////////////////////////////////////

  assign div_signed   = (req_i.op == DIV_DIV) || (req_i.op == DIV_REM);
  assign div_rem      = (req_i.op == DIV_REM) || (req_i.op == DIV_REMU);
  assign op_a_neg     = req_i.op_a[31] & div_signed;
  assign op_b_neg     = req_i.op_b[31] & div_signed;
  assign op_b_zero    = ~|req_i.op_b;
  assign signs_differ = op_a_neg ^ op_b_neg;

  // Negative divisor counts leading ones, one position short so the
  // aligned divisor keeps its sign bit
  assign norm_data = op_b_neg ? {~req_i.op_b[30:0], 1'b1} : req_i.op_b;

  div_norm i_norm (
    .data_i    (norm_data),
    .op_b_i    (req_i.op_b),
    .clz_o     (norm_clz),
    .shifted_o (norm_shifted)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////////////////////

  // Remainder starts as the dividend, negated when the signs differ
  assign init_pos = init_en & ~(div_signed & signs_differ);

  // Shared adder, loads the dividend on init and subtracts afterwards
  assign add_a   = init_en ? req_i.op_a : divisor_q;
  assign add_b   = init_en ? 32'd0 : rem_q;
  assign add_out = init_pos ? (add_b + add_a) : (add_b - add_a);

  // Greater-or-equal in magnitude, flipped for a negative divisor
  // Zero remainder never produces a bit, except for division by zero
  assign comp_out = ((rem_q == divisor_q) || ((rem_q > divisor_q) ^ comp_inv_q)) &&
                    ((|rem_q) || op_b_zero);

  // Result select and sign correction
  assign res_mux = rem_sel_q ? rem_q : quo_q;
  assign res_out = res_inv_q ? (32'd0 - res_mux) : res_mux;
  assign rsp_o   = '{result: res_out, tag: tag_q};

  ////////////////////////////////////////////////////////////////////////////
  // Counter
  ////////////////////////////////////////////////////////////////////////////

  // Padding fills the cycles a full 32 bit division would have used
  assign cnt_pad  = 6'd32 - norm_clz;
  assign cnt_zero = ~|cnt_q;

  // Pad load takes one cycle itself, hence the minus one
  assign cnt_d = init_en   ? norm_clz :
                 pad_load  ? cnt_pad - 6'd1 :
                 !cnt_zero ? cnt_q - 6'd1 :
                 cnt_q;

  ////////////////////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin : p_fsm
    state_d    = state_q;
    valid_o    = 1'b0;
    init_en    = 1'b0;
    pad_load   = 1'b0;
    rem_en     = 1'b0;
    divisor_en = 1'b0;
    quo_en     = 1'b0;

    case (state_q)
      DIV_IDLE: begin
        // Load cycle, only once the dispatcher holds a request here
        if (valid_i) begin
          init_en    = 1'b1;
          rem_en     = 1'b1;
          divisor_en = 1'b1;
          state_d    = DIV_DIVIDE;
        end
      end
      DIV_DIVIDE: begin
        rem_en     = comp_out;
        divisor_en = 1'b1;
        quo_en     = 1'b1;
        // Counter at zero marks the last quotient bit
        if (cnt_zero) begin
          if (data_ind_timing_i && |cnt_pad) begin
            pad_load = 1'b1;
            state_d  = DIV_DUMMY;
          end else begin
            state_d = DIV_FINISH;
          end
        end
      end
      DIV_DUMMY: begin
        if (cnt_zero) begin
          state_d = DIV_FINISH;
        end
      end
      DIV_FINISH: begin
        // Hold the result until the collector takes it
        valid_o = 1'b1;
        if (ready_i) begin
          state_d = DIV_IDLE;
        end
      end
      default: begin
        state_d = DIV_IDLE;
      end
    endcase

    // Dropped request kills the operation in any state
    if (!valid_i) begin
      state_d = DIV_IDLE;
      valid_o = 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin : p_ctrl
    if (!rst_n) begin
      state_q    <= DIV_IDLE;
      cnt_q      <= '0;
      rem_sel_q  <= 1'b0;
      comp_inv_q <= 1'b0;
      res_inv_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
      if (init_en) begin
        rem_sel_q  <= div_rem;
        comp_inv_q <= op_b_neg;
        // Quotient of a division by zero stays all ones
        res_inv_q  <= (!op_b_zero || div_rem) && div_signed && signs_differ;
      end
    end
  end

  always_ff @(posedge clk) begin : p_data
    if (rem_en) begin
      rem_q <= add_out;
    end
    // Divisor walks right, sign extended for a negative divisor
    if (divisor_en) begin
      divisor_q <= init_en ? norm_shifted : {comp_inv_q, divisor_q[31:1]};
    end
    if (init_en) begin
      quo_q <= '0;
      tag_q <= req_i.tag;
    end else if (quo_en) begin
      quo_q <= {quo_q[30:0], comp_out};
    end
  end

endmodule

`default_nettype wire

// File: verilog/div_dispatch.sv
/* Request dispatcher
   Tracks lane occupancy and steers each request strobe to the lowest free lane */

`default_nettype none

`include "div_defines.svh"

module div_dispatch (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic                                    req_valid_i,
  input  div_pkg::div_req_t                       req_i,
  input  logic              [`DIV_N_LANES-1:0]    lane_done_i,
  output logic              [`DIV_N_LANES-1:0]    lane_valid_o,
  output div_pkg::div_req_t [`DIV_N_LANES-1:0]    lane_req_o,
  output logic                                    busy_o
);

  import div_pkg::*;

  logic     [`DIV_N_LANES-1:0] occ_q;
  logic     [`DIV_N_LANES-1:0] occ_d;
  logic     [`DIV_N_LANES-1:0] free_lanes;
  logic     [`DIV_N_LANES-1:0] pick_oh;
  logic     [`DIV_N_LANES-1:0] load_oh;
  div_req_t [`DIV_N_LANES-1:0] req_q;

  ////////////////////////////////////////////////////////////////////////////
  // Lane selection
  ////////////////////////////////////////////////////////////////////////////

  assign free_lanes = ~occ_q;

  // Isolate the lowest set bit, all zero when every lane is taken
  assign pick_oh = free_lanes & (~free_lanes + 1'b1);
  assign load_oh = req_valid_i ? pick_oh : '0;

  // A lane frees up in the cycle its result is granted
  assign occ_d = (occ_q & ~lane_done_i) | load_oh;

  always_ff @(posedge clk or negedge rst_n) begin : p_occ
    if (!rst_n) begin
      occ_q <= '0;
    end else begin
      occ_q <= occ_d;
    end
  end

  // Request is held in its lane register for the whole operation
  always_ff @(posedge clk) begin : p_req
    for (int i = 0; i < `DIV_N_LANES; i++) begin
      if (load_oh[i]) begin
        req_q[i] <= req_i;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////////////////////

  assign lane_valid_o = occ_q;
  assign lane_req_o   = req_q;
  assign busy_o       = &occ_q;

endmodule

`default_nettype wire

// File: verilog/div_collect.sv
/* Result collector
   Round-robin drain of finished lanes into one registered result strobe */

`default_nettype none

`include "div_defines.svh"

module div_collect (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic              [`DIV_N_LANES-1:0]    lane_valid_i,
  input  div_pkg::div_rsp_t [`DIV_N_LANES-1:0]    lane_rsp_i,
  output logic              [`DIV_N_LANES-1:0]    lane_ready_o,
  output logic                                    rsp_valid_o,
  output div_pkg::div_rsp_t                       rsp_o
);

  import div_pkg::*;

  // Index width, lane count never exceeds 8
  localparam int IDX_W = 3;

  logic [IDX_W-1:0]        last_q;
  logic [IDX_W-1:0]        grant_idx;
  logic [`DIV_N_LANES-1:0] grant;
  logic                    grant_vld;

  ////////////////////////////////////////////////////////////////////////////
  // Round-robin arbiter
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin : p_arb
    int idx;
    grant     = '0;
    grant_idx = last_q;
    grant_vld = 1'b0;
    // Search starts just after the last granted lane and wraps
    for (int k = 1; k <= `DIV_N_LANES; k++) begin
      idx = int'(last_q) + k;
      if (idx >= `DIV_N_LANES) begin
        idx = idx - `DIV_N_LANES;
      end
      if (!grant_vld && lane_valid_i[idx]) begin
        grant_vld  = 1'b1;
        grant[idx] = 1'b1;
        grant_idx  = IDX_W'(idx);
      end
    end
  end

  assign lane_ready_o = grant;

  ////////////////////////////////////////////////////////////////////////////
  // Output register
  ////////////////////////////////////////////////////////////////////////////

  // Pointer starts on the last lane so lane 0 wins first
  always_ff @(posedge clk or negedge rst_n) begin : p_ctrl
    if (!rst_n) begin
      last_q      <= IDX_W'(`DIV_N_LANES - 1);
      rsp_valid_o <= 1'b0;
    end else begin
      rsp_valid_o <= grant_vld;
      if (grant_vld) begin
        last_q <= grant_idx;
      end
    end
  end

  // Response follows its grant by one cycle
  always_ff @(posedge clk) begin : p_rsp
    if (grant_vld) begin
      rsp_o <= lane_rsp_i[grant_idx];
    end
  end

endmodule

`default_nettype wire

// File: verilog/div_cluster_top.sv
/* Integer division cluster
   Dispatcher, parallel serial divider lanes and round-robin result collector */

`default_nettype none

`include "div_defines.svh"

module div_cluster_top (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              data_ind_timing_i,
  input  logic              req_valid_i,
  input  div_pkg::div_req_t req_i,
  output logic              busy_o,
  output logic              rsp_valid_o,
  output div_pkg::div_rsp_t rsp_o
);

  import div_pkg::*;

  // Dispatcher to lanes
  logic     [`DIV_N_LANES-1:0] lane_valid;
  div_req_t [`DIV_N_LANES-1:0] lane_req;

  // Lanes to collector, ready doubles as the occupancy release
  logic     [`DIV_N_LANES-1:0] lane_rsp_valid;
  logic     [`DIV_N_LANES-1:0] lane_ready;
  div_rsp_t [`DIV_N_LANES-1:0] lane_rsp;

  div_dispatch i_dispatch (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_valid_i  (req_valid_i),
    .req_i        (req_i),
    .lane_done_i  (lane_ready),
    .lane_valid_o (lane_valid),
    .lane_req_o   (lane_req),
    .busy_o       (busy_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Divider lanes
  ////////////////////////////////////////////////////////////////////////////

  for (genvar g = 0; g < `DIV_N_LANES; g++) begin : gen_lane
    div_serial i_lane (
      .clk               (clk),
      .rst_n             (rst_n),
      .data_ind_timing_i (data_ind_timing_i),
      .valid_i           (lane_valid[g]),
      .req_i             (lane_req[g]),
      .valid_o           (lane_rsp_valid[g]),
      .ready_i           (lane_ready[g]),
      .rsp_o             (lane_rsp[g])
    );
  end

  div_collect i_collect (
    .clk          (clk),
    .rst_n        (rst_n),
    .lane_valid_i (lane_rsp_valid),
    .lane_rsp_i   (lane_rsp),
    .lane_ready_o (lane_ready),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_o        (rsp_o)
  );

endmodule

`default_nettype wire

// File: tb/div_cluster_properties.sv
/* Division cluster assertions
   Port protocol checks bound into the cluster top level */

`default_nettype none

module div_cluster_properties (
  input logic              clk,
  input logic              rst_n,
  input logic              req_valid_i,
  input logic              busy_o,
  input logic              rsp_valid_o,
  input div_pkg::div_rsp_t rsp_o
);

  timeunit 1ns;
  timeprecision 100ps;

  import div_pkg::*;

  // Count of failed assertions, read from the testbench
  int fail_cnt = 0;

  // Strobe only while a lane is free
  a_req_not_busy: assert property (
    @(posedge clk) disable iff (!rst_n) req_valid_i |-> !busy_o
  ) else begin
    $error("request strobe while all lanes are busy");
    fail_cnt++;
  end

  // Outstanding tags are unique, so a repeated tag means a double strobe
  a_single_strobe: assert property (
    @(posedge clk) disable iff (!rst_n)
      (rsp_valid_o && $past(rsp_valid_o)) |-> (rsp_o.tag != $past(rsp_o.tag))
  ) else begin
    $error("response strobe repeated for one grant");
    fail_cnt++;
  end

  a_rsp_known: assert property (
    @(posedge clk) disable iff (!rst_n) rsp_valid_o |-> !$isunknown(rsp_o)
  ) else begin
    $error("unknown bits on the response");
    fail_cnt++;
  end

endmodule

bind div_cluster_top div_cluster_properties i_props (
  .clk         (clk),
  .rst_n       (rst_n),
  .req_valid_i (req_valid_i),
  .busy_o      (busy_o),
  .rsp_valid_o (rsp_valid_o),
  .rsp_o       (rsp_o)
);

`default_nettype wire

// File: tb/div_cluster_tb.sv
/* Division cluster testbench
   Directed table, back-to-back, timing mode and random checks against a reference model */

`default_nettype none

`include "div_defines.svh"

module div_cluster_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import div_pkg::*;

  localparam int CLK_PERIOD = 8;
  localparam int N_TAGS     = 1 << `DIV_TAG_W;
  localparam int TMO_CYC    = 300;
  localparam int N_RAND     = 200;

  // Table entry, operation with its expected result
  typedef struct packed {
    div_op_e     op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] exp;
  } vec_t;

  localparam int N_VEC = 22;
  localparam vec_t VEC_TBL [N_VEC] = '{
    '{DIV_DIV,  32'h0000_0014, 32'h0000_0006, 32'h0000_0003},
    '{DIV_DIVU, 32'h0000_0014, 32'h0000_0006, 32'h0000_0003},
    '{DIV_REM,  32'h0000_0014, 32'h0000_0006, 32'h0000_0002},
    '{DIV_REMU, 32'h0000_0014, 32'h0000_0006, 32'h0000_0002},
    // Sign combinations, quotient rounds toward zero
    '{DIV_DIV,  32'hFFFF_FFEC, 32'h0000_0006, 32'hFFFF_FFFD},
    '{DIV_REM,  32'hFFFF_FFEC, 32'h0000_0006, 32'hFFFF_FFFE},
    '{DIV_DIV,  32'h0000_0014, 32'hFFFF_FFFA, 32'hFFFF_FFFD},
    '{DIV_REM,  32'h0000_0014, 32'hFFFF_FFFA, 32'h0000_0002},
    '{DIV_DIV,  32'hFFFF_FFEC, 32'hFFFF_FFFA, 32'h0000_0003},
    '{DIV_REM,  32'hFFFF_FFEC, 32'hFFFF_FFFA, 32'hFFFF_FFFE},
    '{DIV_DIVU, 32'hFFFF_FFEC, 32'h0000_0006, 32'h2AAA_AAA7},
    '{DIV_REMU, 32'hFFFF_FFEC, 32'h0000_0006, 32'h0000_0002},
    // Division by zero
    '{DIV_DIV,  32'h1234_5678, 32'h0000_0000, 32'hFFFF_FFFF},
    '{DIV_DIVU, 32'h1234_5678, 32'h0000_0000, 32'hFFFF_FFFF},
    '{DIV_REM,  32'h1234_5678, 32'h0000_0000, 32'h1234_5678},
    '{DIV_REMU, 32'h1234_5678, 32'h0000_0000, 32'h1234_5678},
    '{DIV_REM,  32'hFFFF_FFEC, 32'h0000_0000, 32'hFFFF_FFEC},
    // INT_MIN by minus one
    '{DIV_DIV,  32'h8000_0000, 32'hFFFF_FFFF, 32'h8000_0000},
    '{DIV_DIVU, 32'h8000_0000, 32'hFFFF_FFFF, 32'h0000_0000},
    '{DIV_REM,  32'h8000_0000, 32'hFFFF_FFFF, 32'h0000_0000},
    '{DIV_REMU, 32'h8000_0000, 32'hFFFF_FFFF, 32'h8000_0000},
    '{DIV_DIVU, 32'hFFFF_FFFF, 32'h0000_0001, 32'hFFFF_FFFF}
  };

  // Divisors of very different magnitude for the latency test
  localparam logic [31:0] TIM_DIV [5] = '{
    32'h0000_0001, 32'h0000_0400, 32'h0010_0000, 32'h8000_0000, 32'hFFFF_FFFD
  };

  logic     clk;
  logic     rst_n;
  logic     data_ind;
  logic     req_valid;
  div_req_t req;
  logic     busy;
  logic     rsp_valid;
  div_rsp_t rsp;

  // Scoreboard, expected result per tag
  logic [31:0]           exp_q  [N_TAGS];
  logic                  pend_q [N_TAGS];
  logic [`DIV_TAG_W-1:0] next_tag;
  int                    n_pend;
  int                    n_sent;
  int                    n_rcvd;
  int                    err_cnt;
  time                   send_time;
  time                   rsp_time;
  integer                seed;

  div_cluster_top i_dut (
    .clk               (clk),
    .rst_n             (rst_n),
    .data_ind_timing_i (data_ind),
    .req_valid_i       (req_valid),
    .req_i             (req),
    .busy_o            (busy),
    .rsp_valid_o       (rsp_valid),
    .rsp_o             (rsp)
  );

  initial begin : p_clk
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference model and compare tasks
  ////////////////////////////////////////////////////////////////////////////

  // RISC-V M extension division rules
  function automatic logic [31:0] ref_div(input div_op_e op, input logic [31:0] a,
                                          input logic [31:0] b);
    logic signed [31:0] sa;
    logic signed [31:0] sb;
    logic               ovf;
    sa  = a;
    sb  = b;
    ovf = (a == 32'h8000_0000) && (b == 32'hFFFF_FFFF);
    // Zero divisor gives all ones for a quotient, the dividend for a remainder
    if (b == 0) begin
      return (op == DIV_DIV || op == DIV_DIVU) ? 32'hFFFF_FFFF : a;
    end
    case (op)
      DIV_DIV: begin
        if (ovf) begin
          return a;
        end
        return sa / sb;
      end
      DIV_DIVU: begin
        return a / b;
      end
      DIV_REM: begin
        if (ovf) begin
          return 32'd0;
        end
        return sa % sb;
      end
      default: begin
        return a % b;
      end
    endcase
  endfunction

  task automatic check_rsp(input div_rsp_t got, input div_rsp_t exp, input string what);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s result %h tag %0d, expected %h tag %0d",
               $time, what, got.result, got.tag, exp.result, exp.tag);
      err_cnt++;
    end
  endtask

  task automatic check_busy(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_int(input int got, input int exp, input string what);
    if (got != exp) begin
      $display("** Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  function automatic string verdict(input int mark);
    return (err_cnt == mark) ? "ok" : "FAILED";
  endfunction

  function automatic int last_latency();
    return int'((rsp_time - send_time) / CLK_PERIOD);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Request driver and waits
  ////////////////////////////////////////////////////////////////////////////

  // Called on a falling edge, returns one falling edge later
  // Waits for a free lane and for the next tag to be retired
  task automatic send(input div_op_e op, input logic [31:0] a, input logic [31:0] b,
                      input logic [31:0] exp);
    int n;
    n = 0;
    while ((busy || pend_q[next_tag]) && n < TMO_CYC) begin
      @(negedge clk);
      n++;
    end
    if (busy || pend_q[next_tag]) begin
      $display("Timeout at %0t ns: no free lane or tag, request not sent", $time);
      err_cnt++;
    end else begin
      req_valid = 1'b1;
      req.op    = op;
      req.op_a  = a;
      req.op_b  = b;
      req.tag   = next_tag;
      exp_q[next_tag]  = exp;
      pend_q[next_tag] = 1'b1;
      n_pend++;
      n_sent++;
      send_time = $time;
      next_tag++;
      @(negedge clk);
      req_valid = 1'b0;
    end
  endtask

  // Pending count is sampled on the rising edge, away from the monitor
  task automatic wait_idle();
    int n;
    n = 0;
    while (n_pend != 0 && n < TMO_CYC) begin
      @(posedge clk);
      n++;
    end
    if (n_pend != 0) begin
      $display("Timeout at %0t ns: %0d responses never arrived", $time, n_pend);
      err_cnt++;
      for (int i = 0; i < N_TAGS; i++) begin
        pend_q[i] = 1'b0;
      end
      n_pend = 0;
    end
    @(negedge clk);
  endtask

  task automatic wait_rsp(input int mark);
    int n;
    n = 0;
    while (n_rcvd <= mark && n < TMO_CYC) begin
      @(posedge clk);
      n++;
    end
    if (n_rcvd <= mark) begin
      $display("Timeout at %0t ns: no response while all lanes were taken", $time);
      err_cnt++;
    end
    @(negedge clk);
  endtask

  // Response monitor, results may come back in any order
  initial begin : p_monitor
    div_rsp_t exp_rsp;
    forever begin
      @(negedge clk);
      if (rst_n && rsp_valid) begin
        if (pend_q[rsp.tag] !== 1'b1) begin
          $display("Unexpected response with tag %0d at %0t ns", rsp.tag, $time);
          err_cnt++;
        end else begin
          exp_rsp.result = exp_q[rsp.tag];
          exp_rsp.tag    = rsp.tag;
          check_rsp(rsp, exp_rsp, "response");
          pend_q[rsp.tag] = 1'b0;
          n_pend--;
        end
        n_rcvd++;
        rsp_time = $time;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin : p_main
    int          err_mark;
    int          rcvd_mark;
    int          sent_mark;
    int          lat_ref;
    int          lat_small;
    logic [31:0] rnd;
    logic [31:0] a;
    logic [31:0] b;
    div_op_e     op;
    seed      = 27;
    rst_n     = 1'b0;
    data_ind  = 1'b0;
    req_valid = 1'b0;
    req       = '0;
    next_tag  = '0;
    n_pend    = 0;
    n_sent    = 0;
    n_rcvd    = 0;
    err_cnt   = 0;
    send_time = 0;
    rsp_time  = 0;
    for (int i = 0; i < N_TAGS; i++) begin
      pend_q[i] = 1'b0;
      exp_q[i]  = '0;
    end
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    check_busy(busy, 1'b0, "busy after reset");

    // Each table entry alone
    for (int i = 0; i < N_VEC; i++) begin
      err_mark = err_cnt;
      send(VEC_TBL[i].op, VEC_TBL[i].a, VEC_TBL[i].b, VEC_TBL[i].exp);
      wait_idle();
      $display("vector %0d op %0d %h / %h: %s", i, VEC_TBL[i].op, VEC_TBL[i].a,
               VEC_TBL[i].b, verdict(err_mark));
    end

    // Fill every lane, the slow one first so results overtake it
    err_mark  = err_cnt;
    rcvd_mark = n_rcvd;
    send(DIV_DIVU, 32'hFFFF_FFFF, 32'd1, ref_div(DIV_DIVU, 32'hFFFF_FFFF, 32'd1));
    for (int i = 1; i < `DIV_N_LANES; i++) begin
      a = 32'hFFFF_0000 + i;
      send(DIV_DIVU, a, 32'h0001_0000, ref_div(DIV_DIVU, a, 32'h0001_0000));
    end
    check_busy(busy, 1'b1, "busy with all lanes taken");
    wait_rsp(rcvd_mark);
    check_busy(busy, 1'b0, "busy after first drain");
    wait_idle();
    $display("back-to-back fill of %0d lanes: %s", `DIV_N_LANES, verdict(err_mark));

    // Fixed latency mode, then divisor dependent latency
    err_mark = err_cnt;
    data_ind = 1'b1;
    for (int i = 0; i < 5; i++) begin
      a = 32'h7654_3210;
      send(DIV_DIV, a, TIM_DIV[i], ref_div(DIV_DIV, a, TIM_DIV[i]));
      wait_idle();
      if (i == 0) begin
        lat_ref = last_latency();
      end else begin
        check_int(last_latency(), lat_ref, "latency with fixed timing");
      end
    end
    data_ind = 1'b0;
    send(DIV_DIVU, 32'hFFFF_FFFF, 32'd1, ref_div(DIV_DIVU, 32'hFFFF_FFFF, 32'd1));
    wait_idle();
    lat_small = last_latency();
    send(DIV_DIVU, 32'hFFFF_FFFF, 32'h8000_0000,
         ref_div(DIV_DIVU, 32'hFFFF_FFFF, 32'h8000_0000));
    wait_idle();
    check_int(int'(lat_small > last_latency()), 1, "small divisor slower than large");
    $display("timing modes, fixed latency %0d cycles: %s", lat_ref, verdict(err_mark));

    // Random operands, second half in fixed latency mode
    err_mark  = err_cnt;
    rcvd_mark = n_rcvd;
    sent_mark = n_sent;
    for (int i = 0; i < N_RAND; i++) begin
      if (i == N_RAND / 2) begin
        wait_idle();
        data_ind = 1'b1;
      end
      rnd = $random(seed);
      op  = div_op_e'(rnd[1:0]);
      a   = $random(seed);
      b   = $random(seed);
      // Spread the divisor size, now and then a zero
      b   = b >> rnd[12:8];
      if (rnd[7:4] == 4'd0) begin
        b = '0;
      end
      send(op, a, b, ref_div(op, a, b));
    end
    wait_idle();
    data_ind = 1'b0;
    check_int(n_rcvd - rcvd_mark, n_sent - sent_mark, "random response count");
    $display("random %0d requests: %s", N_RAND, verdict(err_mark));

    $display("summary: %0d requests, %0d responses, %0d errors, %0d assertion failures",
             n_sent, n_rcvd, err_cnt, i_dut.i_props.fail_cnt);
    if (err_cnt == 0 && i_dut.i_props.fail_cnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
+incdir+common
common/div_pkg.sv
div_lane/div_norm.sv
div_lane/div_serial.sv
verilog/div_dispatch.sv
verilog/div_collect.sv
verilog/div_cluster_top.sv
tb/div_cluster_properties.sv
tb/div_cluster_tb.sv
